// File: design/dpe_pkg.sv
`default_nettype none

package dpe_pkg;

//========================================
// Sizes
//========================================
   localparam int NUM_PORTS = 3;           //CPU, Eth 1, Eth 2
   localparam int CNT_W     = 16;          //Every status counter

//========================================
// Encodings
//========================================
   // Header destination code, also the ingress source index
   typedef enum logic [1:0] {
      PORT_CPU   = 2'd0,
      PORT_ETH_1 = 2'd1,
      PORT_ETH_2 = 2'd2,
      PORT_NONE  = 2'd3                    //Discard on sight
   } port_e;

   typedef enum logic [1:0] {
      ST_IDLE,                             //Wait for a complete frame
      ST_ARB,                              //Header decode
      ST_FWD,                              //Stream to egress
      ST_DROP                              //Flush from FIFO
   } sched_state_e;

   typedef enum logic [2:0] {
      REG_ENABLE    = 3'd0,                //Forwarding mask, RW
      REG_CNT_CPU   = 3'd1,                //Frames sent to CPU
      REG_CNT_ETH_1 = 3'd2,                //Frames sent to Eth 1
      REG_CNT_ETH_2 = 3'd3,                //Frames sent to Eth 2
      REG_DROPS     = 3'd4                 //Mask/header drops plus overruns
   } csr_addr_e;

//========================================
// Bundles
//========================================
   // One byte of a frame on any stream
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
      logic       last;                    //Final byte of frame
   } dpe_beat_t;

   typedef struct packed {
      logic       we;                      //Write strobe
      csr_addr_e  addr;
      logic [7:0] wdata;
   } csr_req_t;

endpackage

`default_nettype wire

// File: design/dpe_ingress_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dpe_ingress_fifo #(
   parameter int FIFO_DEPTH = 64           //Bytes, power of two
) (
   input  wire                      clk,
   input  wire                      rst_n,        //Sync, low active
   input  wire dpe_pkg::dpe_beat_t  rx,           //From source
   input  wire                      pop,          //From scheduler
   output dpe_pkg::dpe_beat_t       head,         //FWFT byte
   output logic                     frame_avail,  //Whole frame stored
   output logic                     overrun       //Frame discarded
);

   localparam int              AW       = $clog2(FIFO_DEPTH);
   localparam logic [AW:0]     FULL_LVL = (AW+1)'(FIFO_DEPTH);

//========================================
// Storage and pointers
//========================================
   logic [8:0]  mem [FIFO_DEPTH];          //{data, last}
   logic [AW:0] wr_ptr;                    //Next free slot
   logic [AW:0] commit_ptr;                //End of last whole frame
   logic [AW:0] rd_ptr;                    //Head slot
   logic [AW:0] frame_cnt;                 //Committed, not yet popped
   logic        discard;                   //Dropping rest of frame

   logic        wr_full;
   logic        wr_en;
   logic        empty;
   logic        rd_en;
   logic [8:0]  rd_word;

   // Uncommitted bytes count against space too
   assign wr_full = (wr_ptr - rd_ptr) == FULL_LVL;
   assign wr_en   = rx.valid & ~discard & ~wr_full;
   assign empty   = (rd_ptr == commit_ptr);  //Only whole frames visible
   assign rd_en   = pop & ~empty;
   assign rd_word = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[AW-1:0]] <= {rx.data, rx.last};
      end
   end

//========================================
// Write side with rollback
//========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         discard    <= 1'b0;
      end else if (rx.valid) begin
         if (discard || wr_full) begin
            wr_ptr  <= commit_ptr;          //Forget partial frame
            discard <= ~rx.last;            //Skip until frame end
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
            if (rx.last) begin
               commit_ptr <= wr_ptr + 1'b1; //Frame now visible
            end
         end
      end
   end

   // Single pulse on the closing byte of a lost frame
   assign overrun = rx.valid & rx.last & (discard | wr_full);

//========================================
// Read side
//========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr    <= '0;
         frame_cnt <= '0;
      end else begin
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en & rx.last, rd_en & rd_word[0]})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;  //Commit only
            2'b01:   frame_cnt <= frame_cnt - 1'b1;  //Frame fully read
            default: frame_cnt <= frame_cnt;         //None or both
         endcase
      end
   end

   assign frame_avail = (frame_cnt != '0);
   assign head.valid  = ~empty;
   assign head.data   = rd_word[8:1];
   assign head.last   = rd_word[0];

endmodule

`default_nettype wire

// File: design/dpe_sched.sv
`timescale 1ns/10ps
`default_nettype none

module dpe_sched (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire dpe_pkg::dpe_beat_t            head_cpu,     //FIFO heads
   input  wire dpe_pkg::dpe_beat_t            head_eth_1,
   input  wire dpe_pkg::dpe_beat_t            head_eth_2,
   input  wire [dpe_pkg::NUM_PORTS-1:0]       frame_avail,
   input  wire [dpe_pkg::NUM_PORTS-1:0]       enable_mask,  //From CSR
   output logic [dpe_pkg::NUM_PORTS-1:0]      pop,
   output dpe_pkg::dpe_beat_t                 fwd_beat,     //To egress
   output dpe_pkg::port_e                     fwd_dest,
   output logic                               sent,         //Frame forwarded
   output dpe_pkg::port_e                     sent_dest,
   output logic                               dropped       //Frame dropped
);

   dpe_pkg::sched_state_e state;
   dpe_pkg::port_e        last_served;     //Also the active source
   dpe_pkg::port_e        dest_q;          //Latched header destination
   dpe_pkg::port_e        rr_pick;
   logic                  rr_hit;
   dpe_pkg::dpe_beat_t    cur;             //Head of active source
   dpe_pkg::port_e        hdr_dest;
   logic                  hdr_drop;
   logic                  popping;

//========================================
// Round-robin pick
//========================================
   // Walk down so the nearest source after last_served wins
   always_comb begin
      rr_hit  = 1'b0;
      rr_pick = last_served;
      for (int i = dpe_pkg::NUM_PORTS; i >= 1; i--) begin
         if (frame_avail[(int'(last_served) + i) % dpe_pkg::NUM_PORTS]) begin
            rr_hit  = 1'b1;
            rr_pick = dpe_pkg::port_e'((int'(last_served) + i) % dpe_pkg::NUM_PORTS);
         end
      end
   end

   always_comb begin
      case (last_served)
         dpe_pkg::PORT_ETH_1: cur = head_eth_1;
         dpe_pkg::PORT_ETH_2: cur = head_eth_2;
         default:             cur = head_cpu;
      endcase
   end

//========================================
// Header decode
//========================================
   assign hdr_dest = dpe_pkg::port_e'(cur.data[1:0]);  //Bits [1:0]
   assign hdr_drop = (hdr_dest == dpe_pkg::PORT_NONE) ? 1'b1 : ~enable_mask[hdr_dest];

//========================================
// Control FSM
//========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= dpe_pkg::ST_IDLE;
         last_served <= dpe_pkg::PORT_ETH_2;  //CPU served first
         dest_q      <= dpe_pkg::PORT_NONE;
      end else begin
         case (state)
            dpe_pkg::ST_IDLE: begin
               if (rr_hit) begin
                  last_served <= rr_pick;
                  state       <= dpe_pkg::ST_ARB;
               end
            end
            dpe_pkg::ST_ARB: begin
               dest_q <= hdr_dest;
               state  <= hdr_drop ? dpe_pkg::ST_DROP : dpe_pkg::ST_FWD;
            end
            dpe_pkg::ST_FWD, dpe_pkg::ST_DROP: begin
               if (cur.last) begin
                  state <= dpe_pkg::ST_IDLE;  //Frame fully popped
               end
            end
            default: state <= dpe_pkg::ST_IDLE;
         endcase
      end
   end

//========================================
// Outputs
//========================================
   assign popping = (state == dpe_pkg::ST_FWD) | (state == dpe_pkg::ST_DROP);
   assign pop     = popping ? ({{(dpe_pkg::NUM_PORTS-1){1'b0}}, 1'b1} << last_served) : '0;

   assign fwd_beat.valid = (state == dpe_pkg::ST_FWD);
   assign fwd_beat.data  = cur.data;
   assign fwd_beat.last  = cur.last;
   assign fwd_dest       = dest_q;

   assign sent      = (state == dpe_pkg::ST_FWD) & cur.last;
   assign sent_dest = dest_q;
   assign dropped   = (state == dpe_pkg::ST_DROP) & cur.last;

endmodule

`default_nettype wire

// File: design/dpe_egress_mux.sv
`timescale 1ns/10ps
`default_nettype none

module dpe_egress_mux (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire dpe_pkg::dpe_beat_t  fwd_beat,   //Popped byte
   input  wire dpe_pkg::port_e      fwd_dest,   //Target port
   output dpe_pkg::dpe_beat_t       tx_cpu,
   output dpe_pkg::dpe_beat_t       tx_eth_1,
   output dpe_pkg::dpe_beat_t       tx_eth_2
);

   logic [dpe_pkg::NUM_PORTS-1:0] dest_oh;     //One-hot target
   logic [dpe_pkg::NUM_PORTS-1:0] vld_q;       //Per-port valid
   logic [7:0]                    data_q;      //Shared payload
   logic                          last_q;

   always_comb begin
      case (fwd_dest)
         dpe_pkg::PORT_CPU:   dest_oh = 3'b001;
         dpe_pkg::PORT_ETH_1: dest_oh = 3'b010;
         dpe_pkg::PORT_ETH_2: dest_oh = 3'b100;
         default:             dest_oh = 3'b000;  //No such egress
      endcase
   end

//========================================
// Output registers
//========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= fwd_beat.valid ? dest_oh : '0;  //Others cleared each cycle
      end
   end

   always_ff @(posedge clk) begin
      data_q <= fwd_beat.data;
      last_q <= fwd_beat.last;
   end

   // Last qualified so idle ports stay quiet
   assign tx_cpu.valid   = vld_q[0];
   assign tx_cpu.data    = data_q;
   assign tx_cpu.last    = last_q & vld_q[0];

   assign tx_eth_1.valid = vld_q[1];
   assign tx_eth_1.data  = data_q;
   assign tx_eth_1.last  = last_q & vld_q[1];

   assign tx_eth_2.valid = vld_q[2];
   assign tx_eth_2.data  = data_q;
   assign tx_eth_2.last  = last_q & vld_q[2];

endmodule

`default_nettype wire

// File: design/dpe_csr.sv
`timescale 1ns/10ps
`default_nettype none

module dpe_csr (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire dpe_pkg::csr_req_t            csr_req,      //CPU access
   output logic [dpe_pkg::CNT_W-1:0]         csr_rdata,    //Comb. read
   output logic [dpe_pkg::NUM_PORTS-1:0]     enable_mask,
   input  wire                               sent,         //From scheduler
   input  wire dpe_pkg::port_e               sent_dest,
   input  wire                               dropped,
   input  wire [dpe_pkg::NUM_PORTS-1:0]      overrun       //From FIFOs
);

   logic [dpe_pkg::NUM_PORTS-1:0] enable_q;
   logic [dpe_pkg::CNT_W-1:0]     frm_cnt_q [dpe_pkg::NUM_PORTS];  //Per destination
   logic [dpe_pkg::CNT_W-1:0]     drop_cnt_q;
   logic [2:0]                    drop_inc;                        //0 to 4 per cycle

//========================================
// Enable mask and counters
//========================================
   // Scheduler drop and any FIFO overruns can land together
   always_comb begin
      drop_inc = {2'b00, dropped};
      for (int i = 0; i < dpe_pkg::NUM_PORTS; i++) begin
         drop_inc = drop_inc + {2'b00, overrun[i]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         enable_q   <= '1;                 //All ports open
         drop_cnt_q <= '0;
         for (int p = 0; p < dpe_pkg::NUM_PORTS; p++) begin
            frm_cnt_q[p] <= '0;
         end
      end else begin
         if (csr_req.we && (csr_req.addr == dpe_pkg::REG_ENABLE)) begin
            enable_q <= csr_req.wdata[dpe_pkg::NUM_PORTS-1:0];
         end
         if (sent && (sent_dest != dpe_pkg::PORT_NONE)) begin
            frm_cnt_q[sent_dest] <= frm_cnt_q[sent_dest] + 1'b1;
         end
         drop_cnt_q <= drop_cnt_q + dpe_pkg::CNT_W'(drop_inc);
      end
   end

   assign enable_mask = enable_q;

//========================================
// Read mux
//========================================
   always_comb begin
      case (csr_req.addr)
         dpe_pkg::REG_ENABLE:    csr_rdata = dpe_pkg::CNT_W'(enable_q);
         dpe_pkg::REG_CNT_CPU:   csr_rdata = frm_cnt_q[0];
         dpe_pkg::REG_CNT_ETH_1: csr_rdata = frm_cnt_q[1];
         dpe_pkg::REG_CNT_ETH_2: csr_rdata = frm_cnt_q[2];
         dpe_pkg::REG_DROPS:     csr_rdata = drop_cnt_q;
         default:                csr_rdata = '0;  //Unmapped
      endcase
   end

endmodule

`default_nettype wire

// File: design/dpe_top.sv
`timescale 1ns/10ps
`default_nettype none

module dpe_top #(
   parameter int FIFO_DEPTH = 64           //Per-source buffer, bytes
) (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire dpe_pkg::dpe_beat_t     rx_cpu,       //Ingress streams
   input  wire dpe_pkg::dpe_beat_t     rx_eth_1,
   input  wire dpe_pkg::dpe_beat_t     rx_eth_2,
   output dpe_pkg::dpe_beat_t          tx_cpu,       //Egress streams
   output dpe_pkg::dpe_beat_t          tx_eth_1,
   output dpe_pkg::dpe_beat_t          tx_eth_2,
   input  wire dpe_pkg::csr_req_t      csr_req,
   output logic [dpe_pkg::CNT_W-1:0]   csr_rdata
);

   dpe_pkg::dpe_beat_t                 head_cpu;
   dpe_pkg::dpe_beat_t                 head_eth_1;
   dpe_pkg::dpe_beat_t                 head_eth_2;
   logic [dpe_pkg::NUM_PORTS-1:0]      frame_avail;
   logic [dpe_pkg::NUM_PORTS-1:0]      pop;
   logic [dpe_pkg::NUM_PORTS-1:0]      overrun;
   logic [dpe_pkg::NUM_PORTS-1:0]      enable_mask;
   dpe_pkg::dpe_beat_t                 fwd_beat;
   dpe_pkg::port_e                     fwd_dest;
   logic                               sent;
   dpe_pkg::port_e                     sent_dest;
   logic                               dropped;

//========================================
// Ingress FIFOs
//========================================
   dpe_ingress_fifo #(
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) u_fifo_cpu (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx          (rx_cpu),           //i
      .pop         (pop[0]),           //i
      .head        (head_cpu),         //o
      .frame_avail (frame_avail[0]),   //o
      .overrun     (overrun[0])        //o
   );

   dpe_ingress_fifo #(
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) u_fifo_eth_1 (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx          (rx_eth_1),
      .pop         (pop[1]),
      .head        (head_eth_1),
      .frame_avail (frame_avail[1]),
      .overrun     (overrun[1])
   );

   dpe_ingress_fifo #(
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) u_fifo_eth_2 (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx          (rx_eth_2),
      .pop         (pop[2]),
      .head        (head_eth_2),
      .frame_avail (frame_avail[2]),
      .overrun     (overrun[2])
   );

//========================================
// Scheduler, egress and registers
//========================================
   dpe_sched u_sched (
      .clk         (clk),
      .rst_n       (rst_n),
      .head_cpu    (head_cpu),
      .head_eth_1  (head_eth_1),
      .head_eth_2  (head_eth_2),
      .frame_avail (frame_avail),
      .enable_mask (enable_mask),      //From CSR
      .pop         (pop),
      .fwd_beat    (fwd_beat),
      .fwd_dest    (fwd_dest),
      .sent        (sent),
      .sent_dest   (sent_dest),
      .dropped     (dropped)
   );

   dpe_egress_mux u_egress (
      .clk         (clk),
      .rst_n       (rst_n),
      .fwd_beat    (fwd_beat),
      .fwd_dest    (fwd_dest),
      .tx_cpu      (tx_cpu),
      .tx_eth_1    (tx_eth_1),
      .tx_eth_2    (tx_eth_2)
   );

   dpe_csr u_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_req     (csr_req),
      .csr_rdata   (csr_rdata),
      .enable_mask (enable_mask),
      .sent        (sent),
      .sent_dest   (sent_dest),
      .dropped     (dropped),
      .overrun     (overrun)
   );

endmodule

`default_nettype wire

// File: test/tb_dpe.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dpe;

//========================================
// DUT, clock and scoreboard state
//========================================
   logic                      clk = 1'b0;
   logic                      rst_n;
   dpe_pkg::dpe_beat_t        rx [3];             //Indexed by source
   dpe_pkg::dpe_beat_t        tx [3];             //Indexed by egress port
   dpe_pkg::csr_req_t         csr_req;
   logic [dpe_pkg::CNT_W-1:0] csr_rdata;

   integer     seed       = 92;
   int         err_cnt    = 0;
   int         chk_frames = 0;
   int         pending    = 0;                    //Frames owed to egress
   int         exp_drops  = 0;
   int         exp_fwd [3] = '{0, 0, 0};
   logic [2:0] en_model   = 3'b111;               //Mirror of REG_ENABLE
   int         exp_id [3][3][$];                  //[source][dest], in order
   logic [7:0] frm_byte [4096];
   int         frm_base [512];
   int         frm_len [512];
   int         frm_num    = 0;
   int         byte_num   = 0;
   logic [7:0] got [3][32];                       //Egress capture
   int         got_len [3] = '{0, 0, 0};

   always #10 clk = ~clk;

   dpe_top #(.FIFO_DEPTH(64)) i_dut (
      .clk(clk), .rst_n(rst_n),
      .rx_cpu(rx[0]), .rx_eth_1(rx[1]), .rx_eth_2(rx[2]),
      .tx_cpu(tx[0]), .tx_eth_1(tx[1]), .tx_eth_2(tx[2]),
      .csr_req(csr_req), .csr_rdata(csr_rdata)
   );

   function automatic void report_error(input string msg);
      err_cnt++;
      $display("error %0t: %s", $time, msg);
   endfunction

   function automatic int rand_len();
      return 2 + ({$random(seed)} % 19);          //2 to 20 bytes
   endfunction

   // An open frame must keep valid high until its last byte
   a_contig_cpu: assert property (@(posedge clk) disable iff (!rst_n)
      (tx[0].valid && !tx[0].last) |=> tx[0].valid)
      else report_error("cpu egress frame interrupted before last");
   a_contig_eth_1: assert property (@(posedge clk) disable iff (!rst_n)
      (tx[1].valid && !tx[1].last) |=> tx[1].valid)
      else report_error("eth 1 egress frame interrupted before last");
   a_contig_eth_2: assert property (@(posedge clk) disable iff (!rst_n)
      (tx[2].valid && !tx[2].last) |=> tx[2].valid)
      else report_error("eth 2 egress frame interrupted before last");

//========================================
// Stimulus and register access
//========================================
   task automatic send_frame(input int src, input int dest, input int len, input bit fits);
      int         id;
      logic [31:0] rnd;
      logic [7:0] b;
      id = frm_num;
      frm_num++;
      frm_base[id] = byte_num;
      frm_len[id]  = len;
      byte_num     += len;
      if (fits && dest != 3 && en_model[dest]) begin
         exp_id[src][dest].push_back(id);
         pending++;
         exp_fwd[dest]++;
      end else begin
         exp_drops++;                              //Header, mask or overrun
      end
      for (int i = 0; i < len; i++) begin
         rnd = $random(seed);
         if (i == 0) b = {rnd[7:2], 2'(dest)};    //Header carries dest
         else if (i == 1) b = 8'(src);             //Matching key
         else b = rnd[7:0];
         frm_byte[frm_base[id] + i] = b;
         @(negedge clk);
         rx[src] = '{valid: 1'b1, data: b, last: (i == len - 1)};
      end
      @(negedge clk);
      rx[src] = '0;
   endtask

   task automatic run_burst(input int src);
      repeat (4) begin
         send_frame(src, {$random(seed)} % 3, rand_len(), 1'b1);
         repeat (40) @(negedge clk);               //Keeps FIFOs below full
      end
   endtask

   task automatic csr_write(input dpe_pkg::csr_addr_e addr, input logic [7:0] wdata);
      @(negedge clk);
      csr_req = '{we: 1'b1, addr: addr, wdata: wdata};
      if (addr == dpe_pkg::REG_ENABLE) en_model = wdata[2:0];
      @(negedge clk);
      csr_req.we = 1'b0;
   endtask

   task automatic csr_check(input dpe_pkg::csr_addr_e addr, input int exp, input string name);
      @(negedge clk);
      csr_req.addr = addr;
      #5;                                          //Read mux settled
      assert (csr_rdata == dpe_pkg::CNT_W'(exp))
         else report_error($sformatf("%s read %0d, expected %0d", name, csr_rdata, exp));
   endtask

   // Done when every expected frame arrived and all drops are counted
   task automatic wait_drain(input int limit);
      int cyc;
      bit done;
      cyc  = 0;
      done = 1'b0;
      while (!done && cyc < limit) begin
         @(negedge clk);
         csr_req.addr = dpe_pkg::REG_DROPS;
         #5;
         done = (pending == 0) && (csr_rdata == dpe_pkg::CNT_W'(exp_drops));
         cyc++;
      end
      if (!done) begin
         err_cnt++;
         $display("timeout: traffic did not drain within %0d cycles", limit);
      end
   endtask

//========================================
// Egress monitor
//========================================
   task automatic check_frame(input int p);
      int  src;
      int  id;
      bit  ok_src;
      chk_frames++;
      ok_src = (got_len[p] >= 2) && (got[p][1] < 3);
      assert (ok_src) else report_error($sformatf("port %0d frame has bad source byte", p));
      if (ok_src) begin
         src = got[p][1];
         assert (exp_id[src][p].size() > 0)
            else report_error($sformatf("unexpected frame from %0d on port %0d", src, p));
         if (exp_id[src][p].size() > 0) begin
            id = exp_id[src][p].pop_front();
            pending--;
            assert (got_len[p] == frm_len[id])
               else report_error($sformatf("port %0d length %0d, expected %0d",
                                           p, got_len[p], frm_len[id]));
            for (int i = 0; i < frm_len[id] && i < got_len[p] && i < 32; i++) begin
               assert (got[p][i] == frm_byte[frm_base[id] + i])
                  else report_error($sformatf("port %0d byte %0d is %h, expected %h",
                                              p, i, got[p][i], frm_byte[frm_base[id] + i]));
            end
         end
      end
   endtask

   always @(negedge clk) begin
      if (rst_n) begin
         for (int p = 0; p < 3; p++) begin
            if (tx[p].valid) begin
               if (got_len[p] < 32) got[p][got_len[p]] = tx[p].data;
               got_len[p]++;
               if (tx[p].last) begin
                  check_frame(p);
                  got_len[p] = 0;
               end
            end
         end
      end
   end

//========================================
// Test sequence
//========================================
   initial begin
      rst_n   = 1'b0;
      rx      = '{default: '0};
      csr_req = '0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (!tx[0].valid && !tx[1].valid && !tx[2].valid)
         else report_error("egress valid set after reset");
      csr_check(dpe_pkg::REG_ENABLE, 7, "REG_ENABLE after reset");
      for (int s = 0; s < 3; s++) begin            //Each source to each port
         for (int d = 0; d < 3; d++) begin
            repeat (2) send_frame(s, d, rand_len(), 1'b1);
         end
      end
      wait_drain(2000);
      fork                                         //All sources at once
         run_burst(0);
         run_burst(1);
         run_burst(2);
      join
      wait_drain(2000);
      send_frame(2, 3, rand_len(), 1'b1);          //No such port
      wait_drain(500);
      csr_check(dpe_pkg::REG_DROPS, exp_drops, "REG_DROPS after dest 3");
      csr_write(dpe_pkg::REG_ENABLE, 8'h05);       //Close Eth 1
      csr_check(dpe_pkg::REG_ENABLE, 5, "REG_ENABLE readback");
      for (int s = 0; s < 3; s++) send_frame(s, 1, rand_len(), 1'b1);
      wait_drain(1000);
      csr_check(dpe_pkg::REG_DROPS, exp_drops, "REG_DROPS with Eth 1 closed");
      csr_write(dpe_pkg::REG_ENABLE, 8'h07);
      for (int s = 0; s < 3; s++) send_frame(s, 1, rand_len(), 1'b1);
      wait_drain(1000);
      send_frame(1, 0, 70, 1'b0);                  //Exceeds FIFO space
      send_frame(1, 0, rand_len(), 1'b1);
      wait_drain(1000);
      csr_check(dpe_pkg::REG_DROPS, exp_drops, "REG_DROPS after overrun");
      csr_check(dpe_pkg::REG_CNT_CPU, exp_fwd[0], "REG_CNT_CPU");
      csr_check(dpe_pkg::REG_CNT_ETH_1, exp_fwd[1], "REG_CNT_ETH_1");
      csr_check(dpe_pkg::REG_CNT_ETH_2, exp_fwd[2], "REG_CNT_ETH_2");
      $display("frames checked %0d, errors %0d", chk_frames, err_cnt);
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
design/dpe_pkg.sv
design/dpe_ingress_fifo.sv
design/dpe_sched.sv
design/dpe_egress_mux.sv
design/dpe_csr.sv
design/dpe_top.sv
test/tb_dpe.sv

// File: Bender.yml
package:
  name: dpe

sources:
  - files:
      - design/dpe_pkg.sv
      - design/dpe_ingress_fifo.sv
      - design/dpe_sched.sv
      - design/dpe_egress_mux.sv
      - design/dpe_csr.sv
      - design/dpe_top.sv

  - target: test
    files:
      - test/tb_dpe.sv

# Top levels: dpe_top for the design, tb_dpe for simulation
# Compile order matches project.f
